// File: itrc_config_regs.sv
// Configuration register file for enable mask, per-source priorities and threshold
module itrc_config_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_we,
    input  itrc_pkg::cfg_addr_t  cfg_addr,
    input  itrc_pkg::cfg_data_t  cfg_wdata,
    itrc_if.cfg                  bus
);

    logic                        wr_enable;
    logic                        wr_threshold;
    itrc_pkg::src_vec_t          wr_prio;
    logic [itrc_pkg::num_src*itrc_pkg::prio_w-1:0] prio_flat;

    // Address decode
    assign wr_enable    = cfg_we && (cfg_addr == itrc_pkg::addr_enable);
    assign wr_threshold = cfg_we && (cfg_addr == itrc_pkg::addr_threshold);

    always_comb begin
        for (int i = 0; i < itrc_pkg::num_src; i++) begin
            wr_prio[i] = cfg_we &&
                (cfg_addr == itrc_pkg::cfg_addr_t'(itrc_pkg::addr_prio_base + i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.enable    <= '0;
            bus.threshold <= '0;
            // Default priorities come from the LUT
            for (int i = 0; i < itrc_pkg::num_src; i++) begin
                bus.prio[i] <= itrc_pkg::reset_prio_lut[i*itrc_pkg::prio_w +: itrc_pkg::prio_w];
            end
        end else begin
            if (wr_enable) begin
                bus.enable <= cfg_wdata;
            end
            if (wr_threshold) begin
                bus.threshold <= cfg_wdata[itrc_pkg::prio_w-1:0];
            end
            for (int i = 0; i < itrc_pkg::num_src; i++) begin
                if (wr_prio[i]) begin
                    bus.prio[i] <= cfg_wdata[itrc_pkg::prio_w-1:0];
                end
            end
        end
    end

    // Flattened view for the stability check
    always_comb begin
        for (int i = 0; i < itrc_pkg::num_src; i++) begin
            prio_flat[i*itrc_pkg::prio_w +: itrc_pkg::prio_w] = bus.prio[i];
        end
    end

    // Addresses above the threshold slot are holes
    property p_unused_addr_no_effect;
        @(posedge clk) disable iff (!rst_n)
            (cfg_we && (cfg_addr > itrc_pkg::addr_threshold))
                |=> ($stable(bus.enable) && $stable(bus.threshold) && $stable(prio_flat));
    endproperty

    a_unused_addr_no_effect: assert property (p_unused_addr_no_effect)
        else $error("write to unused address %0d changed a register", $past(cfg_addr));

endmodule

// File: itrc_gateway.sv
// Interrupt gateway with rising-edge capture, pending bits and clear on claim
module itrc_gateway (
    input  logic                clk,
    input  logic                rst_n,
    input  itrc_pkg::src_vec_t  int_src,
    input  logic                claim,
    input  itrc_pkg::src_id_t   claim_id,
    itrc_if.gw                  bus
);

    itrc_pkg::src_vec_t src_prev;
    itrc_pkg::src_vec_t rise;
    itrc_pkg::src_vec_t clr_mask;

    // Low last cycle, high now
    assign rise = int_src & ~src_prev;

    // One-hot clear for the claimed source
    always_comb begin
        clr_mask = '0;
        if (claim) begin
            for (int i = 0; i < itrc_pkg::num_src; i++) begin
                if (claim_id == itrc_pkg::src_id_t'(i)) begin
                    clr_mask[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_prev <= '0;
        end else begin
            src_prev <= int_src;
        end
    end

    // A fresh edge overrides a claim on the same line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.pending <= '0;
        end else begin
            bus.pending <= (bus.pending & ~clr_mask) | rise;
        end
    end

    // Claimed bit drops unless re-triggered in the same cycle
    property p_claim_clears;
        @(posedge clk) disable iff (!rst_n)
            (claim && ((rise & (itrc_pkg::src_vec_t'(1) << claim_id)) == '0))
                |=> ((bus.pending & (itrc_pkg::src_vec_t'(1) << $past(claim_id))) == '0);
    endproperty

    a_claim_clears: assert property (p_claim_clears)
        else $error("pending bit %0d still set after claim", $past(claim_id));

endmodule

// File: itrc_if.sv
// Interface bundling pending, enable, priority and threshold state for the encoder
interface itrc_if;

    // Edge-captured requests
    itrc_pkg::src_vec_t pending;

    // Configuration state
    itrc_pkg::src_vec_t enable;
    itrc_pkg::prio_t    prio [itrc_pkg::num_src];
    itrc_pkg::prio_t    threshold;

    // Gateway side
    modport gw (
        output pending
    );

    // Register file side
    modport cfg (
        output enable,
        output prio,
        output threshold
    );

    // Encoder reads everything
    modport enc (
        input pending,
        input enable,
        input prio,
        input threshold
    );

endinterface

// File: itrc_pkg.sv
// Interrupt controller package with source count, field widths, vector typedefs and register map
package itrc_pkg;

    // Number of interrupt lines
    localparam int num_src = 8;

    // Field widths
    localparam int prio_w = 4;
    localparam int id_w = 4;
    localparam int addr_w = 4;
    localparam int data_w = 8;

    // One bit per source
    typedef logic [num_src-1:0] src_vec_t;

    // Priority level where 0 never interrupts
    typedef logic [prio_w-1:0] prio_t;

    // Source number
    typedef logic [id_w-1:0] src_id_t;

    // Configuration write port
    typedef logic [addr_w-1:0] cfg_addr_t;
    typedef logic [data_w-1:0] cfg_data_t;

    // Register map
    localparam cfg_addr_t addr_enable = 4'd0;
    // Priorities of sources 0..7 sit at addresses 1..8
    localparam cfg_addr_t addr_prio_base = 4'd1;
    localparam cfg_addr_t addr_threshold = 4'd9;

    // Nibble i holds the reset priority of source i
    localparam logic [num_src*prio_w-1:0] reset_prio_lut = 32'h0123_4567;

endpackage

// File: itrc_priority_encoder.sv
// Priority encoder with masking, pairwise comparator tree, threshold test and output registers
module itrc_priority_encoder (
    input  logic               clk,
    input  logic               rst_n,
    itrc_if.enc                bus,
    output logic               irq,
    output itrc_pkg::src_id_t  highest_id,
    output itrc_pkg::prio_t    highest_prio
);

    itrc_pkg::prio_t   masked_prio [itrc_pkg::num_src];

    // Tree levels, halving at each step
    itrc_pkg::prio_t   lvl1_prio [itrc_pkg::num_src/2];
    itrc_pkg::src_id_t lvl1_id   [itrc_pkg::num_src/2];
    itrc_pkg::prio_t   lvl2_prio [itrc_pkg::num_src/4];
    itrc_pkg::src_id_t lvl2_id   [itrc_pkg::num_src/4];

    itrc_pkg::prio_t   win_prio;
    itrc_pkg::src_id_t win_id;
    logic              win_valid;

    // Only pending and enabled sources compete
    always_comb begin
        for (int i = 0; i < itrc_pkg::num_src; i++) begin
            if (bus.pending[i] && bus.enable[i]) begin
                masked_prio[i] = bus.prio[i];
            end else begin
                masked_prio[i] = '0;
            end
        end
    end

    // First level compares neighbouring sources, lower index wins ties
    for (genvar i = 0; i < itrc_pkg::num_src/2; i++) begin : g_lvl1
        assign lvl1_prio[i] = (masked_prio[2*i] >= masked_prio[2*i+1]) ?
                              masked_prio[2*i] : masked_prio[2*i+1];
        assign lvl1_id[i]   = (masked_prio[2*i] >= masked_prio[2*i+1]) ?
                              itrc_pkg::src_id_t'(2*i) : itrc_pkg::src_id_t'(2*i+1);
    end

    for (genvar i = 0; i < itrc_pkg::num_src/4; i++) begin : g_lvl2
        assign lvl2_prio[i] = (lvl1_prio[2*i] >= lvl1_prio[2*i+1]) ?
                              lvl1_prio[2*i] : lvl1_prio[2*i+1];
        assign lvl2_id[i]   = (lvl1_prio[2*i] >= lvl1_prio[2*i+1]) ?
                              lvl1_id[2*i] : lvl1_id[2*i+1];
    end

    // Final level
    assign win_prio = (lvl2_prio[0] >= lvl2_prio[1]) ? lvl2_prio[0] : lvl2_prio[1];
    assign win_id   = (lvl2_prio[0] >= lvl2_prio[1]) ? lvl2_id[0] : lvl2_id[1];

    // Strictly above threshold
    assign win_valid = (win_prio > bus.threshold);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq          <= 1'b0;
            highest_id   <= '0;
            highest_prio <= '0;
        end else begin
            irq          <= win_valid;
            highest_prio <= win_prio;
            // Hold the last winner so a claim never names an idle source
            if (win_valid) begin
                highest_id <= win_id;
            end
        end
    end

    // A raised irq always carries a real priority from a live request
    property p_irq_has_prio;
        @(posedge clk) disable iff (!rst_n)
            irq |-> ((highest_prio > 0) && $past(|(bus.pending & bus.enable)));
    endproperty

    a_irq_has_prio: assert property (p_irq_has_prio)
        else $error("irq high with zero priority");

endmodule

// File: itrc_top.sv
// Interrupt controller top level joining gateway, config registers and priority encoder
module itrc_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  itrc_pkg::src_vec_t   int_src,
    input  logic                 cfg_we,
    input  itrc_pkg::cfg_addr_t  cfg_addr,
    input  itrc_pkg::cfg_data_t  cfg_wdata,
    input  logic                 claim,
    output logic                 irq,
    output itrc_pkg::src_id_t    highest_id,
    output itrc_pkg::prio_t      highest_prio
);

    // Shared state between the three blocks
    itrc_if bus_if ();

    itrc_gateway gateway_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .int_src  (int_src),
        .claim    (claim),
        .claim_id (highest_id),
        .bus      (bus_if.gw)
    );

    itrc_config_regs config_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .bus       (bus_if.cfg)
    );

    // Registered winner feeds back as the claim target
    itrc_priority_encoder priority_encoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus_if.enc),
        .irq          (irq),
        .highest_id   (highest_id),
        .highest_prio (highest_prio)
    );

endmodule

// File: tb_itrc.sv
// Table-driven testbench for the interrupt controller with reference model, check task and timeout
module tb_itrc;
    timeunit 1ns;
    timeprecision 1ps;

    // Row operations
    localparam int op_wr = 0;
    localparam int op_src = 1;
    localparam int op_clm = 2;
    localparam int op_clm_src = 3;
    localparam int op_rnd = 4;
    localparam int num_rnd = 16;

    logic                 clk;
    logic                 rst_n;
    itrc_pkg::src_vec_t   int_src;
    logic                 cfg_we;
    itrc_pkg::cfg_addr_t  cfg_addr;
    itrc_pkg::cfg_data_t  cfg_wdata;
    logic                 claim;
    logic                 irq;
    itrc_pkg::src_id_t    highest_id;
    itrc_pkg::prio_t      highest_prio;

    // Stimulus table, one entry per row in each queue
    string row_name [$];
    int    row_op [$];
    int    row_addr [$];
    int    row_data [$];
    int    row_irq [$];
    int    row_id [$];
    int    row_prio [$];

    // Reference model state
    itrc_pkg::src_vec_t m_pending;
    itrc_pkg::src_vec_t m_enable;
    itrc_pkg::src_vec_t m_prev;
    int                 m_prio [8];
    int                 m_thresh;
    int                 m_irq;
    int                 m_id;
    int                 m_out_prio;

    int seed;
    int cycle_cnt;
    int cycle_limit;

    itrc_top itrc_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_src      (int_src),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .claim        (claim),
        .irq          (irq),
        .highest_id   (highest_id),
        .highest_prio (highest_prio)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Simulation timed out after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input string name, input int op, input int addr, input int data,
                           input int exp_irq, input int exp_id, input int exp_prio);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_irq.push_back(exp_irq);
        row_id.push_back(exp_id);
        row_prio.push_back(exp_prio);
    endtask

    task automatic build_table();
        // Sources pulse with the mask closed, then the mask opens
        add_row("mask_off_pulse", op_src, 0, 'hff, 0, 0, 0);
        add_row("mask_off_low", op_src, 0, 'h00, 0, 0, 0);
        add_row("mask_on", op_wr, 0, 'hff, 1, 0, 7);
        // Walk down the reset priorities
        add_row("claim_0", op_clm, 0, 0, 1, 1, 6);
        add_row("claim_1", op_clm, 0, 0, 1, 2, 5);
        add_row("claim_2", op_clm, 0, 0, 1, 3, 4);
        add_row("claim_3", op_clm, 0, 0, 1, 4, 3);
        add_row("claim_4", op_clm, 0, 0, 1, 5, 2);
        add_row("claim_5", op_clm, 0, 0, 1, 6, 1);
        add_row("claim_6", op_clm, 0, 0, 0, 6, 0);
        // Reprogrammed priorities and ties
        add_row("prio5_15", op_wr, 6, 'h0f, 0, 6, 0);
        add_row("src5_edge", op_src, 0, 'h20, 1, 5, 15);
        add_row("src_many", op_src, 0, 'h26, 1, 5, 15);
        add_row("claim_5b", op_clm, 0, 0, 1, 1, 6);
        add_row("prio2_9", op_wr, 3, 'h09, 1, 2, 9);
        add_row("tie_prio1_9", op_wr, 2, 'h09, 1, 1, 9);
        add_row("claim_1b", op_clm, 0, 0, 1, 2, 9);
        add_row("claim_2b", op_clm, 0, 0, 0, 2, 0);
        // Threshold, source 3 sits below it at first
        add_row("thresh_6", op_wr, 9, 'h06, 0, 2, 0);
        add_row("src_low", op_src, 0, 'h00, 0, 2, 0);
        add_row("src3_below", op_src, 0, 'h08, 0, 2, 4);
        add_row("prio3_7", op_wr, 4, 'h07, 1, 3, 7);
        add_row("claim_3b", op_clm, 0, 0, 0, 3, 0);
        add_row("thresh_0", op_wr, 9, 'h00, 0, 3, 0);
        // Edge capture on source 3
        add_row("src3_held", op_src, 0, 'h08, 0, 3, 0);
        add_row("src3_low", op_src, 0, 'h00, 0, 3, 0);
        add_row("src3_rise", op_src, 0, 'h08, 1, 3, 7);
        add_row("src3_low2", op_src, 0, 'h00, 1, 3, 7);
        // Hole in the map while source 3 drives irq
        add_row("unused_addr", op_wr, 12, 'h0f, 1, 3, 7);
        add_row("claim_edge_3", op_clm_src, 0, 'h08, 1, 3, 7);
        add_row("claim_3c", op_clm, 0, 0, 0, 3, 0);
        add_row("src3_held2", op_src, 0, 'h08, 0, 3, 0);
        for (int k = 0; k < num_rnd; k++) begin
            add_row($sformatf("random_%0d", k), op_rnd, 0, 0, 0, 0, 0);
        end
    endtask

    task automatic reset_model();
        m_pending = '0;
        m_enable = '0;
        m_prev = '0;
        m_thresh = 0;
        m_irq = 0;
        m_id = 0;
        m_out_prio = 0;
        for (int i = 0; i < 8; i++) begin
            m_prio[i] = 7 - i;
        end
    endtask

    // Highest enabled pending priority, lowest number on ties
    task automatic predict_outputs();
        int best_p;
        int best_id;
        int p;
        best_p = 0;
        best_id = 0;
        for (int i = 0; i < 8; i++) begin
            p = (m_pending[i] && m_enable[i]) ? m_prio[i] : 0;
            if (p > best_p) begin
                best_p = p;
                best_id = i;
            end
        end
        m_irq = (best_p > m_thresh) ? 1 : 0;
        if (m_irq != 0) begin
            m_id = best_id;
        end
        m_out_prio = best_p;
    endtask

    task automatic update_model(input int op, input int addr, input int data);
        itrc_pkg::src_vec_t rise;
        rise = itrc_pkg::src_vec_t'(data) & ~m_prev;
        if (op == op_wr) begin
            if (addr == 0) begin
                m_enable = itrc_pkg::src_vec_t'(data);
            end else if (addr >= 1 && addr <= 8) begin
                m_prio[addr-1] = data & 'hf;
            end else if (addr == 9) begin
                m_thresh = data & 'hf;
            end
        end
        if (op == op_clm || op == op_clm_src) begin
            m_pending[m_id] = 1'b0;
        end
        // New edge is applied after the clear so it wins
        if (op == op_src || op == op_clm_src) begin
            m_pending = m_pending | rise;
            m_prev = itrc_pkg::src_vec_t'(data);
        end
        predict_outputs();
    endtask

    task automatic apply_row(input int idx);
        int op;
        int addr;
        int data;
        int r;
        op = row_op[idx];
        addr = row_addr[idx];
        data = row_data[idx];
        if (op == op_rnd) begin
            r = $random(seed);
            if (m_irq != 0 && (r & 1) != 0) begin
                op = op_clm;
            end else begin
                op = op_src;
                data = $random(seed) & 'hff;
            end
        end
        case (op)
            op_wr: begin
                cfg_we = 1'b1;
                cfg_addr = itrc_pkg::cfg_addr_t'(addr);
                cfg_wdata = itrc_pkg::cfg_data_t'(data);
            end
            op_src: int_src = itrc_pkg::src_vec_t'(data);
            op_clm: claim = 1'b1;
            default: begin
                claim = 1'b1;
                int_src = itrc_pkg::src_vec_t'(data);
            end
        endcase
        update_model(op, addr, data);
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
        claim = 1'b0;
        @(posedge clk);
        #1;
        if (row_op[idx] != op_rnd) begin
            check_val({row_name[idx], " table irq"}, row_irq[idx], m_irq);
            check_val({row_name[idx], " table id"}, row_id[idx], m_id);
            check_val({row_name[idx], " table prio"}, row_prio[idx], m_out_prio);
        end
        check_val({row_name[idx], " irq"}, m_irq, 32'(irq));
        check_val({row_name[idx], " highest_id"}, m_id, 32'(highest_id));
        check_val({row_name[idx], " highest_prio"}, m_out_prio, 32'(highest_prio));
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        int_src = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        claim = 1'b0;
        seed = 28311;
        cycle_cnt = 0;
        build_table();
        cycle_limit = row_op.size() * 4 + 100;
        reset_model();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < row_op.size(); k++) begin
            apply_row(k);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// File: vlog.f
itrc_pkg.sv
itrc_if.sv
itrc_gateway.sv
itrc_config_regs.sv
itrc_priority_encoder.sv
itrc_top.sv
tb_itrc.sv
